// ==== anti_theft.f ====
+incdir+source
source/anti_theft_pkg.sv
source/input_conditioner.sv
source/delay_timer.sv
source/anti_theft_fsm.sv
source/fuel_pump_fsm.sv
source/status_lamp.sv
source/anti_theft_top.sv
tests/anti_theft_tb.sv

// ==== source/anti_theft_fsm.sv ====
`timescale 1ns/1ns

module anti_theft_fsm import anti_theft_pkg::*; (
   input  logic              clock_25mhz,
   input  logic              reset_sync,
   input  vehicle_switches_t switches,
   input  logic              reprogram,
   input  logic              expired,
   input  time_value_t       countdown,
   output timer_request_t    timer_request,
   output lamp_mode_t        lamp_mode,
   output logic              alarm,
   output ats_status_t       status
);

   alarm_state_t state;
   alarm_state_t state_next;
   logic         door_open;          // either door

   assign door_open = switches.driver_door || switches.passenger_door;

   ////////////////////
   // next state and timer start

   always_comb
   begin
      state_next             = state;
      timer_request.start    = 1'b0;
      timer_request.interval = ARM_DELAY;
      case (state)
         ARMED:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (switches.driver_door)
            begin
               state_next             = TRIGGERED;
               timer_request.start    = 1'b1;
               timer_request.interval = DRIVER_DELAY;
            end
            else if (switches.passenger_door)
            begin
               state_next             = TRIGGERED;
               timer_request.start    = 1'b1;
               timer_request.interval = PASSENGER_DELAY;
            end
         end
         TRIGGERED:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (expired)
               state_next = SOUND_ALARM;
         end
         SOUND_ALARM:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (!door_open)
            begin
               state_next             = EXPIRING_ALARM;   // alarm keeps going for a while
               timer_request.start    = 1'b1;
               timer_request.interval = ALARM_ON;
            end
         end
         EXPIRING_ALARM:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (expired)
               state_next = ARMED;
            else if (door_open)
               state_next = SOUND_ALARM;
         end
         DISARMED:
         begin
            if (!switches.ignition)
               state_next = DISARMED_1;
         end
         DISARMED_1:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (switches.driver_door)
               state_next = DISARMED_2;   // driver getting out
         end
         DISARMED_2:
         begin
            if (switches.ignition)
               state_next = DISARMED;
            else if (!switches.driver_door)
            begin
               state_next             = DISARMED_3;
               timer_request.start    = 1'b1;
               timer_request.interval = ARM_DELAY;
            end
         end
         DISARMED_3:
         begin
            if (switches.ignition || door_open)
               state_next = DISARMED;
            else if (expired)
               state_next = ARMED;
         end
         default:
            state_next = ARMED;
      endcase
      // reprogram rearms and cancels any start
      if (reprogram)
      begin
         state_next          = ARMED;
         timer_request.start = 1'b0;
      end
   end

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
         state <= ARMED;
      else
         state <= state_next;
   end

   ////////////////////
   // outputs decoded from state

   always_comb
   begin
      case (state)
         ARMED:                                 lamp_mode = LAMP_BLINK;
         TRIGGERED, SOUND_ALARM, EXPIRING_ALARM: lamp_mode = LAMP_ON;
         default:                               lamp_mode = LAMP_OFF;
      endcase
   end

   assign alarm  = (state == SOUND_ALARM) || (state == EXPIRING_ALARM);
   assign status = '{state: state, countdown: countdown};

endmodule

// ==== source/anti_theft_pkg.sv ====
`include "anti_theft_settings.svh"

package anti_theft_pkg;

   typedef logic [`ATS_TIME_W-1:0] time_value_t;

   // which stored time parameter to use
   typedef enum logic [1:0] {
      ARM_DELAY       = 2'd0,
      DRIVER_DELAY    = 2'd1,
      PASSENGER_DELAY = 2'd2,
      ALARM_ON        = 2'd3
   } interval_t;

   typedef enum logic [2:0] {
      ARMED          = 3'd0,
      TRIGGERED      = 3'd1,
      SOUND_ALARM    = 3'd2,
      EXPIRING_ALARM = 3'd3,
      DISARMED       = 3'd4,
      DISARMED_1     = 3'd5,
      DISARMED_2     = 3'd6,
      DISARMED_3     = 3'd7
   } alarm_state_t;

   typedef enum logic [1:0] {
      LAMP_OFF   = 2'd0,
      LAMP_BLINK = 2'd1,
      LAMP_ON    = 2'd2
   } lamp_mode_t;

   ////////////////////
   // grouped signals

   typedef struct packed {
      logic ignition;
      logic driver_door;
      logic passenger_door;
      logic brake;        // brake pedal pressed
      logic hidden;       // concealed fuel pump switch
   } vehicle_switches_t;

   typedef struct packed {
      logic        reprogram;
      interval_t   selector;
      time_value_t time_value;
   } program_request_t;

   typedef struct packed {
      logic      start;     // one cycle only
      interval_t interval;
   } timer_request_t;

   typedef struct packed {
      alarm_state_t state;
      time_value_t  countdown;
   } ats_status_t;

endpackage

// ==== source/anti_theft_settings.svh ====
`ifndef ANTI_THEFT_SETTINGS_SVH
`define ANTI_THEFT_SETTINGS_SVH

// width of one time parameter and of the countdown
`define ATS_TIME_W 4

// one second at 25 MHz
`define ATS_TICK_CYCLES_DEFAULT 25000000
// 10 ms of stable switch level
`define ATS_DEBOUNCE_CYCLES_DEFAULT 250000

// time parameters after reset, in seconds
`define ATS_ARM_DELAY_RESET       6
`define ATS_DRIVER_DELAY_RESET    8
`define ATS_PASSENGER_DELAY_RESET 15
`define ATS_ALARM_ON_RESET        10

`endif

// ==== source/anti_theft_top.sv ====
`timescale 1ns/1ns
`include "anti_theft_settings.svh"

module anti_theft_top import anti_theft_pkg::*; #(
   parameter int tick_cycles     = `ATS_TICK_CYCLES_DEFAULT,
   parameter int debounce_cycles = `ATS_DEBOUNCE_CYCLES_DEFAULT
) (
   input  logic              clock_25mhz,
   input  logic              reset_sync,
   input  vehicle_switches_t switches_raw,
   input  program_request_t  program_raw,
   output logic              alarm,
   output logic              fuel_pump_power,
   output logic              status_lamp,
   output ats_status_t       status
);

   vehicle_switches_t switches;
   program_request_t  program_req;
   timer_request_t    timer_request;
   lamp_mode_t        lamp_mode;
   time_value_t       countdown;
   logic              tick;
   logic              expired;

   ////////////////////
   // input conditioning

   input_conditioner #(.payload_t(vehicle_switches_t), .debounce_cycles(debounce_cycles))
      switch_conditioner (
         .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
         .raw(switches_raw), .clean(switches));

   input_conditioner #(.payload_t(program_request_t), .debounce_cycles(debounce_cycles))
      program_conditioner (
         .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
         .raw(program_raw), .clean(program_req));

   ////////////////////
   // functional blocks

   delay_timer #(.tick_cycles(tick_cycles)) timer (
      .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
      .program_req(program_req), .request(timer_request),
      .tick(tick), .expired(expired), .countdown(countdown));

   anti_theft_fsm theft_fsm (
      .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
      .switches(switches), .reprogram(program_req.reprogram),
      .expired(expired), .countdown(countdown),
      .timer_request(timer_request), .lamp_mode(lamp_mode),
      .alarm(alarm), .status(status));

   fuel_pump_fsm pump_fsm (
      .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
      .switches(switches), .fuel_pump_power(fuel_pump_power));

   status_lamp lamp_driver (
      .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
      .mode(lamp_mode), .tick(tick), .lamp(status_lamp));

endmodule

// ==== source/delay_timer.sv ====
`timescale 1ns/1ns
`include "anti_theft_settings.svh"

module delay_timer import anti_theft_pkg::*; #(
   parameter int tick_cycles = `ATS_TICK_CYCLES_DEFAULT
) (
   input  logic                   clock_25mhz,
   input  logic                   reset_sync,
   input  program_request_t       program_req,
   input  timer_request_t         request,
   output logic                   tick,
   output logic                   expired,
   output logic [`ATS_TIME_W-1:0] countdown
);

   localparam int tick_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

   time_value_t       time_param [4];
   logic [tick_w-1:0] tick_count;
   logic              running;        // countdown in progress, expiry not yet signalled

   ////////////////////
   // time parameter store

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         time_param[ARM_DELAY]       <= time_value_t'(`ATS_ARM_DELAY_RESET);
         time_param[DRIVER_DELAY]    <= time_value_t'(`ATS_DRIVER_DELAY_RESET);
         time_param[PASSENGER_DELAY] <= time_value_t'(`ATS_PASSENGER_DELAY_RESET);
         time_param[ALARM_ON]        <= time_value_t'(`ATS_ALARM_ON_RESET);
      end
      else if (program_req.reprogram)
      begin
         time_param[program_req.selector] <= program_req.time_value;
      end
   end

   ////////////////////
   // one second tick, restarted by each start

   assign tick = (tick_count == tick_w'(tick_cycles - 1));

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || request.start)
         tick_count <= '0;
      else if (tick)
         tick_count <= '0;
      else
         tick_count <= tick_count + 1'b1;
   end

   ////////////////////
   // countdown

   always_ff @(posedge clock_25mhz)
   begin
      expired <= 1'b0;                 // strobe
      if (reset_sync)
      begin
         countdown <= '0;
         running   <= 1'b0;
      end
      else if (request.start)
      begin
         countdown <= time_param[request.interval];   // restart wins over a tick
         running   <= 1'b1;
      end
      else if (tick && running)
      begin
         if (countdown == '0)
         begin
            expired <= 1'b1;
            running <= 1'b0;           // only once per start
         end
         else
         begin
            countdown <= countdown - 1'b1;
         end
      end
   end

endmodule

// ==== source/fuel_pump_fsm.sv ====
`timescale 1ns/1ns

module fuel_pump_fsm import anti_theft_pkg::*; (
   input  logic              clock_25mhz,
   input  logic              reset_sync,
   input  vehicle_switches_t switches,
   output logic              fuel_pump_power
);

   typedef enum logic [1:0] {
      PUMP_OFF      = 2'd0,
      RESTORE_START = 2'd1,   // ignition on, waiting for hidden + brake
      RESTORE       = 2'd2,
      LATCH_ON      = 2'd3
   } pump_state_t;

   pump_state_t state;

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
         state <= PUMP_OFF;
      else
      begin
         case (state)
            PUMP_OFF:
               if (switches.ignition)
                  state <= RESTORE_START;
            RESTORE_START:
               if (!switches.ignition)
                  state <= PUMP_OFF;
               else if (switches.hidden && switches.brake)
                  state <= RESTORE;
            RESTORE:
               state <= LATCH_ON;
            default:
               if (!switches.ignition)
                  state <= PUMP_OFF;     // held on until ignition drops
         endcase
      end
   end

   assign fuel_pump_power = (state == LATCH_ON);

endmodule

// ==== source/input_conditioner.sv ====
`timescale 1ns/1ns
`include "anti_theft_settings.svh"

module input_conditioner #(
   parameter type payload_t       = logic,
   parameter int  debounce_cycles = `ATS_DEBOUNCE_CYCLES_DEFAULT
) (
   input  logic     clock_25mhz,
   input  logic     reset_sync,
   input  payload_t raw,
   output payload_t clean
);

   // counter must reach debounce_cycles
   localparam int count_w = (debounce_cycles > 0) ? $clog2(debounce_cycles + 1) : 1;

   payload_t           sync_meta;
   payload_t           sync_out;
   payload_t           pending;        // last value seen after the synchroniser
   logic [count_w-1:0] stable_count;

   ////////////////////
   // two flop synchroniser

   always_ff @(posedge clock_25mhz)
   begin
      sync_meta <= raw;
      sync_out  <= sync_meta;
   end

   ////////////////////
   // debounce the whole word

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         pending      <= sync_out;
         clean        <= sync_out;     // start from the current level
         stable_count <= '0;
      end
      else if (sync_out != pending)
      begin
         pending      <= sync_out;     // any bit moved, start over
         stable_count <= '0;
      end
      else if (stable_count == count_w'(debounce_cycles))
      begin
         clean <= pending;
      end
      else
      begin
         stable_count <= stable_count + 1'b1;
      end
   end

endmodule

// ==== source/status_lamp.sv ====
`timescale 1ns/1ns

module status_lamp import anti_theft_pkg::*; (
   input  logic       clock_25mhz,
   input  logic       reset_sync,
   input  lamp_mode_t mode,
   input  logic       tick,
   output logic       lamp
);

   logic blink_phase;
   logic phase_next;

   assign phase_next = blink_phase ^ tick;   // flips once per second

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         blink_phase <= 1'b0;
         lamp        <= 1'b0;
      end
      else
      begin
         blink_phase <= phase_next;
         case (mode)
            LAMP_BLINK: lamp <= phase_next;
            LAMP_ON:    lamp <= 1'b1;
            default:    lamp <= 1'b0;
         endcase
      end
   end

endmodule

// ==== tests/anti_theft_patterns.txt ====
// first word: number of steps, then one step per line
// switches program state alarm fuel lamp min_ticks max_ticks pulse_cycles
// switches {ignition, driver_door, passenger_door, brake, hidden}, program {reprogram, sel, value}
// lamp 0 off, 1 blink, 2 on; pulse_cycles 0 keeps the inputs, else they fall back afterwards
11
00 00 0 0 0 1 0 1 0   // after reset
08 00 1 0 0 2 0 1 0   // driver door opens
08 00 2 1 0 2 6 8 0   // driver delay 8+1 ticks
00 00 3 1 0 2 0 1 0   // door closed, alarm still on
00 00 0 0 0 1 8 a 0   // alarm on time 10+1 ticks
00 63 0 0 0 1 0 1 0   // passenger delay set to 3
04 00 1 0 0 2 0 1 0   // passenger door opens
04 00 2 1 0 2 1 3 0   // 3+1 ticks
00 00 3 1 0 2 0 1 0
00 00 0 0 0 1 8 a 0
10 00 4 0 0 0 0 1 0   // ignition on
13 00 4 0 1 0 0 1 0   // hidden and brake, pump on
00 00 5 0 0 0 0 1 0   // ignition off, pump off
08 00 6 0 0 0 0 1 0   // driver gets out
00 00 7 0 0 0 0 1 0   // door closed, arm delay runs
00 00 0 0 0 1 4 6 0   // 6+1 ticks
08 00 0 0 0 1 0 1 2   // door glitch, too short to count

// ==== tests/anti_theft_tb.sv ====
`timescale 1ns/1ns
`include "anti_theft_settings.svh"

module anti_theft_tb
   import anti_theft_pkg::*;
();

   localparam int tick_cycles     = 20;
   localparam int debounce_cycles = 4;
   localparam int lamp_window     = 2 * tick_cycles;   // two ticks
   localparam int step_fields     = 9;
   localparam int max_words       = 512;

   logic              clock_25mhz;
   logic              reset_sync;
   vehicle_switches_t switches_raw;
   program_request_t  program_raw;
   logic              alarm;
   logic              fuel_pump_power;
   logic              lamp_out;
   ats_status_t       status;

   logic [15:0] pattern_words [0:max_words-1];
   time_value_t stored_delay [4];   // time parameters as the DUT should hold them
   int          error_count;
   int          failed_steps;

   anti_theft_top #(.tick_cycles(tick_cycles), .debounce_cycles(debounce_cycles)) DUT (
      .clock_25mhz(clock_25mhz), .reset_sync(reset_sync),
      .switches_raw(switches_raw), .program_raw(program_raw),
      .alarm(alarm), .fuel_pump_power(fuel_pump_power),
      .status_lamp(lamp_out), .status(status));

   initial
   begin
      clock_25mhz = 1'b0;
      forever #20 clock_25mhz = ~clock_25mhz;
   end

   ////////////////////
   // compare tasks

   task automatic check_state(input string name, input alarm_state_t actual,
                              input alarm_state_t expected);
      if (actual !== expected)
      begin
         $display("FAIL %0t ns %s: got %s (%0d), expected %s (%0d)", $time, name,
                  actual.name(), actual, expected.name(), expected);
         error_count++;
      end
   endtask

   task automatic check_level(input string name, input logic actual, input logic expected);
      if (actual !== expected)
      begin
         $display("FAIL %0t ns %s: got %b, expected %b", $time, name, actual, expected);
         error_count++;
      end
   endtask

   task automatic check_lamp(input string name, input lamp_mode_t actual,
                             input lamp_mode_t expected);
      if (actual !== expected)
      begin
         $display("FAIL %0t ns %s: got %s, expected %s", $time, name,
                  actual.name(), expected.name());
         error_count++;
      end
   endtask

   task automatic check_count(input string name, input time_value_t actual,
                              input time_value_t expected);
      if (actual !== expected)
      begin
         $display("FAIL %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
         error_count++;
      end
   endtask

   ////////////////////
   // drive and observe

   function automatic logic outputs_match(input alarm_state_t st, input logic al,
                                          input logic fp);
      return (status.state === st) && (alarm === al) && (fuel_pump_power === fp);
   endfunction

   // countdown right after a state is entered, loaded on a timer start
   function automatic time_value_t expected_countdown(input alarm_state_t st,
                                                     input vehicle_switches_t sw);
      case (st)
         TRIGGERED:
            return sw.driver_door ? stored_delay[DRIVER_DELAY]
                                  : stored_delay[PASSENGER_DELAY];
         EXPIRING_ALARM: return stored_delay[ALARM_ON];
         DISARMED_3:     return stored_delay[ARM_DELAY];
         default:        return '0;   // other states here follow an expiry or no start
      endcase
   endfunction

   task automatic drive_inputs(input vehicle_switches_t sw, input program_request_t prog,
                               input int pulse);
      vehicle_switches_t sw_held;
      program_request_t  prog_held;
      int                n;
      sw_held   = switches_raw;
      prog_held = program_raw;
      @(posedge clock_25mhz);
      #2;
      switches_raw = sw;
      program_raw  = prog;
      if (pulse > 0)
      begin
         for (n = 0; n < pulse; n++)
            @(posedge clock_25mhz);
         #2;
         switches_raw = sw_held;   // glitch ends
         program_raw  = prog_held;
      end
   endtask

   task automatic wait_for_outputs(input alarm_state_t st, input logic al, input logic fp,
                                   input int max_ticks, output int cycles, output bit found);
      cycles = 0;
      found  = outputs_match(st, al, fp);
      while (!found && cycles < max_ticks * tick_cycles)
      begin
         @(negedge clock_25mhz);
         cycles++;
         found = outputs_match(st, al, fp);
      end
   endtask

   // blinking if the lamp moves within two ticks
   task automatic watch_lamp(input alarm_state_t st, input logic al, input logic fp,
                             input bit settled, output lamp_mode_t mode);
      logic first;
      logic last;
      int   toggles;
      int   n;
      bit   moved;
      toggles = 0;
      moved   = 1'b0;
      @(negedge clock_25mhz);      // lamp lags the state by a cycle
      first = lamp_out;
      last  = lamp_out;
      for (n = 0; n < lamp_window; n++)
      begin
         @(negedge clock_25mhz);
         if (lamp_out !== last)
            toggles++;
         last = lamp_out;
         if (settled && !moved && !outputs_match(st, al, fp))
         begin
            $display("outputs left their expected values during the lamp check at %0t ns",
                     $time);
            error_count++;
            moved = 1'b1;
         end
      end
      if (toggles > 0)
         mode = LAMP_BLINK;
      else if (first === 1'b1)
         mode = LAMP_ON;
      else
         mode = LAMP_OFF;
   endtask

   ////////////////////
   // scenario steps from the pattern file

   initial
   begin
      int                steps;
      int                step;
      int                base;
      int                n;
      int                cycles;
      int                step_errors;
      int                min_ticks;
      int                max_ticks;
      bit                found;
      alarm_state_t      exp_state;
      logic              exp_alarm;
      logic              exp_fuel;
      lamp_mode_t        exp_lamp;
      lamp_mode_t        seen_lamp;
      vehicle_switches_t step_switches;
      program_request_t  step_program;
      reset_sync   = 1'b1;
      switches_raw = '0;
      program_raw  = '0;
      error_count  = 0;
      failed_steps = 0;
      steps        = 0;
      stored_delay[ARM_DELAY]       = time_value_t'(`ATS_ARM_DELAY_RESET);
      stored_delay[DRIVER_DELAY]    = time_value_t'(`ATS_DRIVER_DELAY_RESET);
      stored_delay[PASSENGER_DELAY] = time_value_t'(`ATS_PASSENGER_DELAY_RESET);
      stored_delay[ALARM_ON]        = time_value_t'(`ATS_ALARM_ON_RESET);
      $readmemh("tests/anti_theft_patterns.txt", pattern_words);
      if (!$isunknown(pattern_words[0]) && pattern_words[0] != 0 &&
          1 + pattern_words[0] * step_fields <= max_words)
      begin
         steps = pattern_words[0];
         for (n = 0; n < 4; n++)
            @(posedge clock_25mhz);
         #2;
         reset_sync = 1'b0;
         for (step = 0; step < steps; step++)
         begin
            base          = 1 + step * step_fields;
            exp_state     = alarm_state_t'(pattern_words[base + 2][2:0]);
            exp_alarm     = pattern_words[base + 3][0];
            exp_fuel      = pattern_words[base + 4][0];
            exp_lamp      = lamp_mode_t'(pattern_words[base + 5][1:0]);
            min_ticks     = pattern_words[base + 6];
            max_ticks     = pattern_words[base + 7];
            step_switches = vehicle_switches_t'(pattern_words[base][4:0]);
            step_program  = program_request_t'(pattern_words[base + 1][6:0]);
            step_errors   = error_count;
            if (step_program.reprogram)
               stored_delay[step_program.selector] = step_program.time_value;
            drive_inputs(step_switches, step_program, pattern_words[base + 8]);
            wait_for_outputs(exp_state, exp_alarm, exp_fuel, max_ticks, cycles, found);
            if (!found)
            begin
               $display("step %0d: expected outputs did not appear within %0d ticks",
                        step, max_ticks);
               error_count++;
            end
            else if (cycles < min_ticks * tick_cycles)
            begin
               $display("step %0d: outputs appeared after %0d cycles, before %0d ticks",
                        step, cycles, min_ticks);
               error_count++;
            end
            check_state("status.state", status.state, exp_state);
            check_level("alarm", alarm, exp_alarm);
            check_level("fuel_pump_power", fuel_pump_power, exp_fuel);
            check_count("status.countdown", status.countdown,
                        expected_countdown(exp_state, step_switches));
            watch_lamp(exp_state, exp_alarm, exp_fuel, found, seen_lamp);
            check_lamp("lamp mode", seen_lamp, exp_lamp);
            if (error_count == step_errors)
               $display("step %0d passed, outputs after %0d cycles", step, cycles);
            else
            begin
               $display("step %0d failed", step);
               failed_steps++;
            end
         end
      end
      else
      begin
         $display("pattern file tests/anti_theft_patterns.txt is missing or malformed");
         error_count++;
      end
      $display("%0d steps run, %0d failed, %0d errors", steps, failed_steps, error_count);
      if (error_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
